// File: build.f
common/lpif_pkg.sv
common/phy_pkg.sv
verilog/ll_auto_sync.sv
lpif_link/lpif_link_packer.sv
lpif_link/lpif_link_framer.sv
verilog/lpif_txrx_top.sv
dv/lpif_txrx_chk.sv
dv/lpif_txrx_tb.sv

// File: Bender.yml
package:
  name: lpif_txrx

sources:
  # Packages first, lpif_pkg is used by phy_pkg
  - common/lpif_pkg.sv
  - common/phy_pkg.sv
  # RTL
  - verilog/ll_auto_sync.sv
  - lpif_link/lpif_link_packer.sv
  - lpif_link/lpif_link_framer.sv
  - verilog/lpif_txrx_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/lpif_txrx_chk.sv
      - dv/lpif_txrx_tb.sv

// File: dv/lpif_txrx_tb.sv
/* Loopback testbench for the LPIF adapter with stimulus, reference model and checks */
`timescale 1ns/1ps
`default_nettype none

module lpif_txrx_tb;

  localparam int               FLITS = 200;
  localparam int               LAT   = 4;
  localparam phy_pkg::delay_t  DLY_X = 3;
  localparam phy_pkg::delay_t  DLY_Y = 2;
  localparam phy_pkg::delay_t  DLY_Z = 5;
  localparam phy_pkg::marker_t MRK   = 2'b10;

  logic                   clk_wr;
  logic                   rst;
  logic                   tx_online;
  logic                   rx_online;
  phy_pkg::phy_word_t     loop_phy;
  lpif_pkg::lpif_state_t  dstrm_state;
  lpif_pkg::lpif_protid_t dstrm_protid;
  lpif_pkg::lpif_data_t   dstrm_data;
  lpif_pkg::lpif_crc_t    dstrm_crc;
  logic                   dstrm_dvalid;
  logic                   dstrm_crc_valid;
  logic                   dstrm_valid;
  lpif_pkg::lpif_state_t  ustrm_state;
  lpif_pkg::lpif_protid_t ustrm_protid;
  lpif_pkg::lpif_data_t   ustrm_data;
  lpif_pkg::lpif_crc_t    ustrm_crc;
  logic                   ustrm_dvalid;
  logic                   ustrm_crc_valid;
  logic                   ustrm_valid;

  // Expected PHY word for each driven flit
  phy_pkg::phy_word_t exp_hist [0:FLITS+LAT-1];
  phy_pkg::phy_word_t cmp_ref;
  logic               lb_active;
  int                 lb_cyc;
  int                 n_checked;
  int                 n;
  integer             seed;
  logic               r_valid;
  logic               r_dvalid;
  logic               r_crc_valid;

  // Random field values of the flit being driven
  lpif_pkg::lpif_state_t  r_state;
  lpif_pkg::lpif_protid_t r_protid;
  lpif_pkg::lpif_data_t   r_data;
  lpif_pkg::lpif_crc_t    r_crc;

  lpif_txrx_top uut (
    .clk_wr (clk_wr), .rst (rst), .tx_online (tx_online), .rx_online (rx_online),
    .tx_phy0 (loop_phy), .rx_phy0 (loop_phy),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .tx_mrk_userbit (MRK), .tx_stb_userbit (1'b1),
    .delay_x_value (DLY_X), .delay_y_value (DLY_Y), .delay_z_value (DLY_Z)
  );

  always #4 clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and helpers

  // PHY word for one flit from the package layout
  function automatic phy_pkg::phy_word_t expected_phy(
      input logic valid, input lpif_pkg::lpif_state_t state,
      input lpif_pkg::lpif_protid_t protid, input logic dvalid,
      input lpif_pkg::lpif_data_t data, input logic crc_valid,
      input lpif_pkg::lpif_crc_t crc, input logic stb, input phy_pkg::marker_t mrk);
    phy_pkg::phy_word_t w;
    w = '0;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_VALID] = valid;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_STATE +: lpif_pkg::STATE_W] = state;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_W] = protid;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_DVALID] = dvalid;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_DATA +: lpif_pkg::DATA_W] = data;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_CRC_VALID] = crc_valid;
    w[phy_pkg::PHY_LINK_OFS + lpif_pkg::OFS_CRC +: lpif_pkg::CRC_W] = crc;
    w[phy_pkg::PHY_STB_POS] = stb;
    w[phy_pkg::PHY_MRK_OFS +: phy_pkg::MARKER_W] = mrk;
    return w;
  endfunction

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input logic [159:0] got, input logic [159:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // Sample at falling edges until the masked PHY word matches
  task automatic wait_phy_match(input phy_pkg::phy_word_t mask,
                                input phy_pkg::phy_word_t want, input int limit,
                                input string what, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
      if (((loop_phy & mask) !== want) && cycles >= limit) begin
        $display("Timeout: %s not seen within %0d cycles", what, limit);
        stop_on_error();
      end
    end while ((loop_phy & mask) !== want);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Loopback comparison with 2 cycles to tx_phy0 and 4 to the upstream ports

  always @(negedge clk_wr) begin
    if (uut.u_framer.u_chk.fail_cnt != 0) begin
      $display("A bound assertion on the framer failed before %0t ns", $time);
      stop_on_error();
    end
    if (!lb_active) begin
      lb_cyc = 0;
    end else begin
      if (lb_cyc >= 2) begin
        check_value(loop_phy, exp_hist[lb_cyc-2], "tx_phy0 in loopback");
      end
      if (lb_cyc >= LAT) begin
        cmp_ref = exp_hist[lb_cyc-LAT];
        check_value(ustrm_valid, cmp_ref[lpif_pkg::OFS_VALID], "ustrm_valid");
        check_value(ustrm_state, cmp_ref[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_W],
                    "ustrm_state");
        check_value(ustrm_protid, cmp_ref[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_W],
                    "ustrm_protid");
        check_value(ustrm_dvalid, cmp_ref[lpif_pkg::OFS_DVALID], "ustrm_dvalid");
        check_value(ustrm_data, cmp_ref[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_W], "ustrm_data");
        check_value(ustrm_crc_valid, cmp_ref[lpif_pkg::OFS_CRC_VALID], "ustrm_crc_valid");
        check_value(ustrm_crc, cmp_ref[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_W], "ustrm_crc");
        if (lb_cyc - LAT < FLITS) n_checked++;
      end
      lb_cyc++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    seed = 46607;
    clk_wr = 1'b0;
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    dstrm_state = '0;
    dstrm_protid = '0;
    dstrm_data = '0;
    dstrm_crc = '0;
    dstrm_dvalid = 1'b0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid = 1'b0;
    lb_active = 1'b0;
    n_checked = 0;
    repeat (4) @(posedge clk_wr);
    rst <= 1'b0;

    // Reset state
    @(negedge clk_wr);
    check_value(loop_phy, '0, "tx_phy0 after reset");
    check_value({ustrm_valid, ustrm_dvalid, ustrm_crc_valid, ustrm_state, ustrm_protid,
                 ustrm_crc}, '0, "upstream fields after reset");
    check_value(ustrm_data, '0, "ustrm_data after reset");

    // Online delay until the marker is the first nonzero content
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    wait_phy_match(expected_phy(0, 0, 0, 0, 0, 0, 0, 0, 2'b11),
                   expected_phy(0, 0, 0, 0, 0, 0, 0, 0, MRK), 8, "marker bits", n);
    check_value(n > DLY_Z, 1'b1, "tx_phy0 nonzero before the online delay");
    check_value(loop_phy, expected_phy(0, 0, 0, 0, 0, 0, 0, 0, MRK), "first online word");

    // Strobe follows after the strobe delay
    wait_phy_match(expected_phy(0, 0, 0, 0, 0, 0, 0, 1, 2'b00),
                   expected_phy(0, 0, 0, 0, 0, 0, 0, 1, 2'b00), DLY_Y + 2, "strobe bit", n);
    check_value(n >= DLY_Y, 1'b1, "strobe before the strobe delay");
    check_value(loop_phy[phy_pkg::PHY_MRK_OFS +: phy_pkg::MARKER_W], MRK, "persistent marker");

    // Random flits followed by all-valid flits while the tail drains
    for (int i = 0; i < FLITS + LAT; i++) begin
      @(posedge clk_wr);
      r_valid     = (i >= FLITS) || (($random(seed) & 7) != 0);
      r_dvalid    = (i >= FLITS) || (($random(seed) & 7) != 0);
      r_crc_valid = (i >= FLITS) || (($random(seed) & 7) != 0);
      r_state     = lpif_pkg::lpif_state_t'($random(seed));
      r_protid    = lpif_pkg::lpif_protid_t'($random(seed));
      r_crc       = lpif_pkg::lpif_crc_t'($random(seed));
      r_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
      dstrm_valid     <= r_valid;
      dstrm_dvalid    <= r_dvalid;
      dstrm_crc_valid <= r_crc_valid;
      dstrm_state     <= r_state;
      dstrm_protid    <= r_protid;
      dstrm_crc       <= r_crc;
      dstrm_data      <= r_data;
      exp_hist[i] = expected_phy(r_valid, r_state, r_protid, r_dvalid, r_data,
                                 r_crc_valid, r_crc, 1'b1, MRK);
      lb_active = 1'b1;
    end

    // Going offline with valid flits still in flight
    @(posedge clk_wr);
    lb_active = 1'b0;
    tx_online <= 1'b0;
    // Receive side drops while the last flits still reach rx_phy0
    rx_online <= 1'b0;
    // Two edges to clear, seen at the third falling edge
    wait_phy_match('1, '0, 3, "tx_phy0 cleared after tx_online low", n);
    n = 0;
    do begin
      @(negedge clk_wr);
      n++;
      if ((ustrm_valid || ustrm_dvalid || ustrm_crc_valid) && n >= LAT) begin
        $display("Timeout: upstream valid bits still set %0d cycles after offline", LAT);
        stop_on_error();
      end
    end while (ustrm_valid || ustrm_dvalid || ustrm_crc_valid);

    check_value(n_checked, FLITS, "number of compared flits");
    if (uut.u_framer.u_chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", uut.u_framer.u_chk.fail_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

`default_nettype wire

// File: dv/lpif_txrx_chk.sv
/* Bound assertions on framer online gating, spare PHY bits and reset state */
`timescale 1ns/1ps
`default_nettype none

module lpif_txrx_chk (
  input logic                 clk_wr,
  input logic                 rst,
  input logic                 tx_online_dly,
  input logic                 rx_online_dly,
  input phy_pkg::phy_word_t   tx_phy0,
  input lpif_pkg::link_word_t rx_link_word
);

  // Count of assertion failures
  int unsigned fail_cnt = 0;

  // Transmit word gated while not online
  a_tx_gate: assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online_dly |=> tx_phy0 == '0)
    else begin
      fail_cnt++;
      $error("tx_phy0 not zero after tx_online_dly low");
    end

  // Spare bits never set
  a_pad_zero: assert property (@(posedge clk_wr) disable iff (rst)
    tx_phy0[phy_pkg::PHY_PAD_OFS +: phy_pkg::PHY_PAD_W] == '0)
    else begin
      fail_cnt++;
      $error("spare bits of tx_phy0 set");
    end

  // Receive slice gated while not online
  a_rx_gate: assert property (@(posedge clk_wr) disable iff (rst)
    !rx_online_dly |=> rx_link_word == '0)
    else begin
      fail_cnt++;
      $error("rx_link_word not zero after rx_online_dly low");
    end

  // Both framer registers clear on reset
  a_reset: assert property (@(posedge clk_wr)
    rst |=> (tx_phy0 == '0 && rx_link_word == '0))
    else begin
      fail_cnt++;
      $error("framer registers not cleared by reset");
    end

endmodule

bind lpif_link_framer lpif_txrx_chk u_chk (
  .clk_wr        (clk_wr),
  .rst           (rst),
  .tx_online_dly (tx_online_dly),
  .rx_online_dly (rx_online_dly),
  .tx_phy0       (tx_phy0),
  .rx_link_word  (rx_link_word)
);

`default_nettype wire

// File: verilog/lpif_txrx_top.sv
/* Single-channel LPIF adapter top level with auto-sync, packer and framer */
`timescale 1ns/1ps
`default_nettype none

module lpif_txrx_top (
  input  logic                   clk_wr,
  input  logic                   rst,

  // Raw online indications
  input  logic                   tx_online,
  input  logic                   rx_online,

  // PHY words
  output phy_pkg::phy_word_t     tx_phy0,
  input  phy_pkg::phy_word_t     rx_phy0,

  // Downstream channel
  input  lpif_pkg::lpif_state_t  dstrm_state,
  input  lpif_pkg::lpif_protid_t dstrm_protid,
  input  lpif_pkg::lpif_data_t   dstrm_data,
  input  logic                   dstrm_dvalid,
  input  lpif_pkg::lpif_crc_t    dstrm_crc,
  input  logic                   dstrm_crc_valid,
  input  logic                   dstrm_valid,

  // Upstream channel
  output lpif_pkg::lpif_state_t  ustrm_state,
  output lpif_pkg::lpif_protid_t ustrm_protid,
  output lpif_pkg::lpif_data_t   ustrm_data,
  output logic                   ustrm_dvalid,
  output lpif_pkg::lpif_crc_t    ustrm_crc,
  output logic                   ustrm_crc_valid,
  output logic                   ustrm_valid,

  // Configuration
  input  phy_pkg::marker_t       tx_mrk_userbit,
  input  logic                   tx_stb_userbit,
  input  phy_pkg::delay_t        delay_x_value,
  input  phy_pkg::delay_t        delay_y_value,
  input  phy_pkg::delay_t        delay_z_value
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                 tx_online_dly;
  logic                 rx_online_dly;
  logic                 tx_auto_stb;
  phy_pkg::marker_t     tx_auto_mrk;
  lpif_pkg::link_word_t tx_link_word;
  lpif_pkg::link_word_t rx_link_word;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks

  ll_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_online_dly  (tx_online_dly),
    .rx_online_dly  (rx_online_dly),
    .tx_auto_stb    (tx_auto_stb),
    .tx_auto_mrk    (tx_auto_mrk)
  );

  // FIFO and credit logic bypassed, packer feeds the framer directly
  lpif_link_packer u_packer (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_crc       (dstrm_crc),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_crc       (ustrm_crc),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_link_word    (tx_link_word),
    .rx_link_word    (rx_link_word)
  );

  lpif_link_framer u_framer (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online_dly (tx_online_dly),
    .rx_online_dly (rx_online_dly),
    .tx_auto_stb   (tx_auto_stb),
    .tx_auto_mrk   (tx_auto_mrk),
    .tx_link_word  (tx_link_word),
    .rx_link_word  (rx_link_word),
    .tx_phy0       (tx_phy0),
    .rx_phy0       (rx_phy0)
  );

endmodule

`default_nettype wire

// File: lpif_link/lpif_link_framer.sv
/* Registered mapping between the link word and the 160-bit PHY words */
`timescale 1ns/1ps
`default_nettype none

module lpif_link_framer (
  input  logic                 clk_wr,
  input  logic                 rst,

  // From auto-sync
  input  logic                 tx_online_dly,
  input  logic                 rx_online_dly,
  input  logic                 tx_auto_stb,
  input  phy_pkg::marker_t     tx_auto_mrk,

  // Link words to and from the packer
  input  lpif_pkg::link_word_t tx_link_word,
  output lpif_pkg::link_word_t rx_link_word,

  // PHY words
  output phy_pkg::phy_word_t   tx_phy0,
  input  phy_pkg::phy_word_t   rx_phy0
);

  // Transmit word before the output register
  phy_pkg::phy_word_t tx_phy_next;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit

  always_comb begin
    tx_phy_next = '0;
    tx_phy_next[phy_pkg::PHY_LINK_OFS +: phy_pkg::PHY_LINK_W] = tx_link_word;
    tx_phy_next[phy_pkg::PHY_STB_POS]                         = tx_auto_stb;
    tx_phy_next[phy_pkg::PHY_MRK_OFS +: phy_pkg::MARKER_W]    = tx_auto_mrk;
    // Spare bits stay at zero
    tx_phy_next[phy_pkg::PHY_PAD_OFS +: phy_pkg::PHY_PAD_W]   = '0;
  end

  // Nothing leaves until the transmit side is online
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
    end else if (tx_online_dly) begin
      tx_phy0 <= tx_phy_next;
    end else begin
      tx_phy0 <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive

  // Only the link slice is kept, user bits are not forwarded
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_link_word <= '0;
    end else if (rx_online_dly) begin
      rx_link_word <= rx_phy0[phy_pkg::PHY_LINK_OFS +: phy_pkg::PHY_LINK_W];
    end else begin
      rx_link_word <= '0;
    end
  end

endmodule

`default_nettype wire

// File: lpif_link/lpif_link_packer.sv
/* Downstream LPIF fields into the link word, received link word into upstream fields */
`timescale 1ns/1ps
`default_nettype none

module lpif_link_packer (
  input  logic                  clk_wr,
  input  logic                  rst,

  // Downstream flit from the LPIF side
  input  lpif_pkg::lpif_state_t  dstrm_state,
  input  lpif_pkg::lpif_protid_t dstrm_protid,
  input  lpif_pkg::lpif_data_t   dstrm_data,
  input  lpif_pkg::lpif_crc_t    dstrm_crc,
  input  logic                   dstrm_dvalid,
  input  logic                   dstrm_crc_valid,
  input  logic                   dstrm_valid,

  // Upstream flit to the LPIF side
  output lpif_pkg::lpif_state_t  ustrm_state,
  output lpif_pkg::lpif_protid_t ustrm_protid,
  output lpif_pkg::lpif_data_t   ustrm_data,
  output lpif_pkg::lpif_crc_t    ustrm_crc,
  output logic                   ustrm_dvalid,
  output logic                   ustrm_crc_valid,
  output logic                   ustrm_valid,

  // Link words to and from the framer
  output lpif_pkg::link_word_t   tx_link_word,
  input  lpif_pkg::link_word_t   rx_link_word
);

  ////////////////////////////////////////////////////////////////////////////
  // Pack

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_link_word <= '0;
    end else begin
      tx_link_word[lpif_pkg::OFS_VALID]                         <= dstrm_valid;
      tx_link_word[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_W]    <= dstrm_state;
      tx_link_word[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_W]  <= dstrm_protid;
      tx_link_word[lpif_pkg::OFS_DVALID]                        <= dstrm_dvalid;
      tx_link_word[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_W]      <= dstrm_data;
      tx_link_word[lpif_pkg::OFS_CRC_VALID]                     <= dstrm_crc_valid;
      tx_link_word[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_W]        <= dstrm_crc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Unpack

  // No handshake, every word is presented as received
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ustrm_valid     <= 1'b0;
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_data      <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_crc       <= '0;
    end else begin
      ustrm_valid     <= rx_link_word[lpif_pkg::OFS_VALID];
      ustrm_state     <= rx_link_word[lpif_pkg::OFS_STATE +: lpif_pkg::STATE_W];
      ustrm_protid    <= rx_link_word[lpif_pkg::OFS_PROTID +: lpif_pkg::PROTID_W];
      ustrm_dvalid    <= rx_link_word[lpif_pkg::OFS_DVALID];
      ustrm_data      <= rx_link_word[lpif_pkg::OFS_DATA +: lpif_pkg::DATA_W];
      ustrm_crc_valid <= rx_link_word[lpif_pkg::OFS_CRC_VALID];
      ustrm_crc       <= rx_link_word[lpif_pkg::OFS_CRC +: lpif_pkg::CRC_W];
    end
  end

endmodule

`default_nettype wire

// File: verilog/ll_auto_sync.sv
/* Online delay counters with persistent strobe and marker generation */
`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync (
  input  logic             clk_wr,
  input  logic             rst,

  // Raw online indications
  input  logic             tx_online,
  input  logic             rx_online,

  // Delays in clocks
  input  phy_pkg::delay_t  delay_x_value,
  input  phy_pkg::delay_t  delay_y_value,
  input  phy_pkg::delay_t  delay_z_value,

  // User bits to send once online
  input  phy_pkg::marker_t tx_mrk_userbit,
  input  logic             tx_stb_userbit,

  output logic             tx_online_dly,
  output logic             rx_online_dly,
  output logic             tx_auto_stb,
  output phy_pkg::marker_t tx_auto_mrk
);

  // Word alignment, strobe start and transmit enable counters
  phy_pkg::delay_t cnt_x;
  phy_pkg::delay_t cnt_y;
  phy_pkg::delay_t cnt_z;

  // Next-state terms for the registered outputs
  logic tx_ready;
  logic stb_ready;

  // Count up and hold at the limit
  function automatic phy_pkg::delay_t sat_inc(input phy_pkg::delay_t cnt,
                                              input phy_pkg::delay_t lim);
    if (cnt < lim) begin
      return phy_pkg::delay_t'(cnt + phy_pkg::delay_t'(1));
    end
    return cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Transmit enable

  // Online seen on z+1 consecutive edges
  assign tx_ready = tx_online && (cnt_z >= delay_z_value);

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      cnt_z         <= '0;
      tx_online_dly <= 1'b0;
      tx_auto_mrk   <= '0;
    end else begin
      // Low online restarts the count
      cnt_z         <= tx_online ? sat_inc(cnt_z, delay_z_value) : '0;
      tx_online_dly <= tx_ready;
      // Persistent marker, tracks the user bits while enabled
      tx_auto_mrk   <= tx_ready ? tx_mrk_userbit : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe start

  // Enabled side has held for y more edges
  assign stb_ready = tx_online && tx_online_dly && (cnt_y >= delay_y_value);

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      cnt_y       <= '0;
      tx_auto_stb <= 1'b0;
    end else begin
      // Only counts once transmit is enabled
      cnt_y       <= (tx_online && tx_online_dly) ? sat_inc(cnt_y, delay_y_value) : '0;
      // Persistent strobe
      tx_auto_stb <= stb_ready && tx_stb_userbit;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive word alignment

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      cnt_x         <= '0;
      rx_online_dly <= 1'b0;
    end else begin
      cnt_x         <= rx_online ? sat_inc(cnt_x, delay_x_value) : '0;
      rx_online_dly <= rx_online && (cnt_x >= delay_x_value);
    end
  end

endmodule

`default_nettype wire

// File: common/phy_pkg.sv
/* PHY word type, strobe and marker positions, marker and delay types */
`default_nettype none

package phy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int PHY_WORD_W = 160;
  localparam int MARKER_W   = 2;
  // Delay counts are in clk_wr cycles
  localparam int DELAY_W    = 16;

  ////////////////////////////////////////////////////////////////////////////
  // PHY word positions

  // Link word in the low bits
  localparam int PHY_LINK_OFS = 0;
  localparam int PHY_LINK_W   = lpif_pkg::LINK_WORD_W;
  // Strobe user bit
  localparam int PHY_STB_POS  = 153;
  // Two marker user bits
  localparam int PHY_MRK_OFS  = 154;
  // Spare bits, always driven zero
  localparam int PHY_PAD_OFS  = 156;
  localparam int PHY_PAD_W    = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [PHY_WORD_W-1:0] phy_word_t;
  typedef logic [MARKER_W-1:0]   marker_t;
  typedef logic [DELAY_W-1:0]    delay_t;

endpackage

`default_nettype wire

// File: common/lpif_pkg.sv
/* LPIF field widths, field types and the bit layout of the 153-bit link word */
`default_nettype none

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 16;

  // Whole flit, gen2 full-rate layout
  localparam int LINK_WORD_W = 153;

  ////////////////////////////////////////////////////////////////////////////
  // Link word layout, packed from bit 0 upward

  localparam int OFS_VALID     = 0;
  localparam int OFS_STATE     = 1;
  localparam int OFS_PROTID    = 5;
  localparam int OFS_DVALID    = 7;
  localparam int OFS_DATA      = 8;
  localparam int OFS_CRC_VALID = 136;
  // CRC sits on top and ends at bit 152
  localparam int OFS_CRC       = 137;

  ////////////////////////////////////////////////////////////////////////////
  // Field types

  typedef logic [STATE_W-1:0]     lpif_state_t;
  typedef logic [PROTID_W-1:0]    lpif_protid_t;
  typedef logic [DATA_W-1:0]      lpif_data_t;
  typedef logic [CRC_W-1:0]       lpif_crc_t;

  // Packed flit as carried between packer and framer
  typedef logic [LINK_WORD_W-1:0] link_word_t;

endpackage

`default_nettype wire
